// ==== id_allocator.sv ====
`timescale 1ns/1ns
`include "tracker_settings.svh"

module id_allocator (
    input  logic             clk,
    input  logic             rst,
    // Fetch request and retirement return
    input  logic             fetch_valid,
    input  logic             retire_valid,
    input  tracker_pkg::id_t retire_id,
    // Pool status and accept strobe
    output logic             id_available,
    output tracker_pkg::id_t free_id,
    output logic             fetch_take
);
    import tracker_pkg::*;

    // Circular list of IDs not currently in use
    id_t              free_list [`MAX_IDS];
    logic [`ID_W-1:0] rd_ptr;
    logic [`ID_W-1:0] wr_ptr;
    logic [`ID_W:0]   count;

    ////////////////////////////////////////////////////////////////////////////
    // Pool outputs

    assign id_available = (count != '0);
    // Fetch is dropped when the pool is empty
    assign fetch_take   = fetch_valid && id_available;
    assign free_id      = free_list[rd_ptr];

    ////////////////////////////////////////////////////////////////////////////
    // Free list contents

    // Every ID starts out free
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MAX_IDS; i++) begin
                free_list[i] <= id_t'(i);
            end
        end else if (retire_valid) begin
            free_list[wr_ptr] <= retire_id;
        end
    end

    // Pointers wrap at the list depth
    // Simultaneous pop and push leave the count alone
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= (`ID_W+1)'(`MAX_IDS);
        end else begin
            if (fetch_take) begin
                rd_ptr <= (rd_ptr == (`ID_W)'(`MAX_IDS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (retire_valid) begin
                wr_ptr <= (wr_ptr == (`ID_W)'(`MAX_IDS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            case ({fetch_take, retire_valid})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== instr_tracker_top.sv ====
`timescale 1ns/1ns
`include "tracker_settings.svh"

module instr_tracker_top (
    input  logic                      clk,
    input  logic                      rst,
    // Fetch
    input  logic                      fetch_valid,
    input  tracker_pkg::fetch_pkt_t   fetch,
    output logic                      id_available,
    output tracker_pkg::id_t          free_id,
    // Decode
    input  tracker_pkg::id_t          decode_id,
    output logic [31:0]               decode_pc,
    output tracker_pkg::instr_word_u  decode_word,
    // Issue
    input  logic                      issue_valid,
    input  tracker_pkg::issue_pkt_t   issue,
    output tracker_pkg::id_t          rs_id [`READ_PORTS],
    output logic                      rs_inuse [`READ_PORTS],
    // Completion
    input  logic                      complete_valid,
    input  tracker_pkg::id_t          complete_id,
    // Retirement
    output logic                      retire_valid,
    output tracker_pkg::retire_pkt_t  retire
);
    import tracker_pkg::*;

    logic       fetch_take;
    id_t        head_id;
    logic [4:0] head_rd_addr;
    logic       head_rd_latest;

    // Free pool
    id_allocator u_alloc (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .retire_valid (retire_valid),
        .retire_id    (retire.id),
        .id_available (id_available),
        .free_id      (free_id),
        .fetch_take   (fetch_take)
    );

    // Tables and rename lookups
    instruction_metadata u_meta (
        .clk              (clk),
        .rst              (rst),
        .fetch_take       (fetch_take),
        .fetch_id         (free_id),
        .fetch            (fetch),
        .decode_id        (decode_id),
        .decode_pc        (decode_pc),
        .decode_word      (decode_word),
        .issue_valid      (issue_valid),
        .issue            (issue),
        .rs_id            (rs_id),
        .rs_inuse         (rs_inuse),
        .retire_valid     (retire_valid),
        .retire_id        (retire.id),
        .head_id          (head_id),
        .retire_rd_addr   (head_rd_addr),
        .retire_rd_latest (head_rd_latest)
    );

    // In-order retirement
    retire_unit u_retire (
        .clk            (clk),
        .rst            (rst),
        .issue_valid    (issue_valid),
        .issue_id       (issue.id),
        .complete_valid (complete_valid),
        .complete_id    (complete_id),
        .head_rd_addr   (head_rd_addr),
        .head_rd_latest (head_rd_latest),
        .head_id        (head_id),
        .retire_valid   (retire_valid),
        .retire         (retire)
    );

endmodule

// ==== instruction_metadata.sv ====
`timescale 1ns/1ns
`include "tracker_settings.svh"

module instruction_metadata (
    input  logic                     clk,
    input  logic                     rst,
    // Fetch
    input  logic                     fetch_take,
    input  tracker_pkg::id_t         fetch_id,
    input  tracker_pkg::fetch_pkt_t  fetch,
    // Decode
    input  tracker_pkg::id_t         decode_id,
    output logic [31:0]              decode_pc,
    output tracker_pkg::instr_word_u decode_word,
    // Issue
    input  logic                     issue_valid,
    input  tracker_pkg::issue_pkt_t  issue,
    output tracker_pkg::id_t         rs_id [`READ_PORTS],
    output logic                     rs_inuse [`READ_PORTS],
    // Retirement
    input  logic                     retire_valid,
    input  tracker_pkg::id_t         retire_id,
    input  tracker_pkg::id_t         head_id,
    output logic [4:0]               retire_rd_addr,
    output logic                     retire_rd_latest
);
    import tracker_pkg::*;

    // Per-ID tables
    logic [31:0]         pc_table [`MAX_IDS];
    logic [31:0]         word_table [`MAX_IDS];
    logic [`MAX_IDS-1:0] in_flight;

    // Newest issued writer of each architectural register
    id_t                 rename_table [32];

    // Field views of the words read back from the table
    instr_word_u         rs_word [`READ_PORTS];
    instr_word_u         head_word;

    ////////////////////////////////////////////////////////////////////////////
    // Table updates

    // PC and raw word captured at fetch accept
    always_ff @(posedge clk) begin
        if (fetch_take) begin
            pc_table[fetch_id]   <= fetch.pc;
            word_table[fetch_id] <= fetch.word.raw;
        end
    end

    // Set at fetch, cleared at retirement
    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            if (retire_valid) begin
                in_flight[retire_id] <= 1'b0;
            end
            if (fetch_take) begin
                in_flight[fetch_id] <= 1'b1;
            end
        end
    end

    // Only instructions that write rd claim a rename entry
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                rename_table[r] <= '0;
            end
        end else if (issue_valid && issue.uses_rd) begin
            rename_table[issue.rd_addr] <= issue.id;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Lookups

    // Decode read port
    assign decode_pc = pc_table[decode_id];
    assign decode_word.raw = word_table[decode_id];

    // Producer of each source operand
    // x0 never waits, and a stale rename entry is masked by in-flight and rd match
    always_comb begin
        for (int i = 0; i < `READ_PORTS; i++) begin
            rs_id[i] = rename_table[issue.rs_addr[i]];
            rs_word[i].raw = word_table[rs_id[i]];
            rs_inuse[i] = (issue.rs_addr[i] != 5'd0)
                          && in_flight[rs_id[i]]
                          && (rs_word[i].fields.rd == issue.rs_addr[i]);
        end
    end

    // Queue head lookups
    always_comb begin
        head_word.raw = word_table[head_id];
        retire_rd_addr = head_word.fields.rd;
        // Younger writer of the same rd means the head is no longer newest
        retire_rd_latest = (rename_table[head_word.fields.rd] == head_id);
    end

endmodule

// ==== list.f ====
+incdir+.
tracker_pkg.sv
id_allocator.sv
instruction_metadata.sv
retire_unit.sv
instr_tracker_top.sv
tracker_props.sv
tracker_tb.sv

// ==== retire_unit.sv ====
`timescale 1ns/1ns
`include "tracker_settings.svh"

module retire_unit (
    input  logic                      clk,
    input  logic                      rst,
    // Issue order
    input  logic                      issue_valid,
    input  tracker_pkg::id_t          issue_id,
    // Completions in any order
    input  logic                      complete_valid,
    input  tracker_pkg::id_t          complete_id,
    // Table lookups for the head
    input  logic [4:0]                head_rd_addr,
    input  logic                      head_rd_latest,
    output tracker_pkg::id_t          head_id,
    // Retirement pulse
    output logic                      retire_valid,
    output tracker_pkg::retire_pkt_t  retire
);
    import tracker_pkg::*;

    // Issued IDs, oldest at head_ptr
    id_t                 order_q [`MAX_IDS];
    logic [`ID_W-1:0]    head_ptr;
    logic [`ID_W-1:0]    tail_ptr;
    logic [`ID_W:0]      count;

    // Completion flag per ID
    logic [`MAX_IDS-1:0] done;
    logic                pop;

    assign head_id = order_q[head_ptr];
    // Oldest instruction finished
    assign pop = (count != '0) && done[head_id];

    ////////////////////////////////////////////////////////////////////////////
    // Order queue

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            order_q[tail_ptr] <= issue_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (issue_valid) begin
                tail_ptr <= (tail_ptr == (`ID_W)'(`MAX_IDS - 1)) ? '0 : tail_ptr + 1'b1;
            end
            if (pop) begin
                head_ptr <= (head_ptr == (`ID_W)'(`MAX_IDS - 1)) ? '0 : head_ptr + 1'b1;
            end
            case ({issue_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Done bits cleared as the head leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= '0;
        end else begin
            if (pop) begin
                done[head_id] <= 1'b0;
            end
            if (complete_valid) begin
                done[complete_id] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Retire output

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= pop;
        end
    end

    // Payload sampled with the pop
    always_ff @(posedge clk) begin
        if (pop) begin
            retire.id        <= head_id;
            retire.rd_addr   <= head_rd_addr;
            retire.rd_latest <= head_rd_latest;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f list.f --top-module tracker_tb -o tracker_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tracker_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only when the testbench printed its pass line
if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// ==== tracker_pkg.sv ====
`include "tracker_settings.svh"

package tracker_pkg;

    // Tag carried by every instruction from fetch to retirement
    typedef logic [`ID_W-1:0] id_t;

    // R-type layout of a RISC-V instruction word
    // rd sits at bits 11:7, rs1 at 19:15, rs2 at 24:20
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

    // Same 32 bits seen raw or split into fields
    typedef union packed {
        logic [31:0]   raw;
        instr_fields_t fields;
    } instr_word_u;

    // Written into the tables when an ID is handed out
    typedef struct packed {
        logic [31:0] pc;
        instr_word_u word;
    } fetch_pkt_t;

    // Issue request
    // rs_addr holds one register address per read port
    typedef struct packed {
        id_t                          id;
        logic                         uses_rd;
        logic [4:0]                   rd_addr;
        logic [`READ_PORTS-1:0][4:0]  rs_addr;
    } issue_pkt_t;

    // One retirement, in program order
    typedef struct packed {
        id_t        id;
        logic [4:0] rd_addr;
        // Still the newest writer of rd
        logic       rd_latest;
    } retire_pkt_t;

endpackage

// ==== tracker_props.sv ====
`timescale 1ns/1ns
`include "tracker_settings.svh"

module tracker_props (
    input logic                     clk,
    input logic                     rst,
    input logic                     fetch_valid,
    input logic                     id_available,
    input logic                     issue_valid,
    input tracker_pkg::issue_pkt_t  issue,
    input logic                     retire_valid,
    input tracker_pkg::retire_pkt_t retire
);
    import tracker_pkg::*;

    // Set at retirement, cleared when the ID issues again
    logic [`MAX_IDS-1:0] retired;

    always_ff @(posedge clk) begin
        if (rst) begin
            retired <= '0;
        end else begin
            if (retire_valid) begin
                retired[retire.id] <= 1'b1;
            end
            if (issue_valid) begin
                retired[issue.id] <= 1'b0;
            end
        end
    end

    // Reset leaves no retirement pulse behind
    reset_quiet: assert property (@(posedge clk) rst |=> !retire_valid)
        else $error("retire_valid high in the cycle after reset");

    // Empty pool accepts nothing
    // Only a retirement on the same edge may refill it
    drop_keeps_pool: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && !id_available |=> id_available == $past(retire_valid))
        else $error("fetch accepted with no free ID");

    no_double_retire: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> !retired[retire.id])
        else $error("ID retired twice without being issued again");

endmodule

bind instr_tracker_top tracker_props props0 (
    .clk          (clk),
    .rst          (rst),
    .fetch_valid  (fetch_valid),
    .id_available (id_available),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .retire_valid (retire_valid),
    .retire       (retire)
);

// ==== tracker_settings.svh ====
`ifndef TRACKER_SETTINGS_SVH
`define TRACKER_SETTINGS_SVH

// Instructions that may be in flight at once
`define MAX_IDS 8

// Bits needed to name one in-flight instruction
`define ID_W 3

// Source operands looked up at issue
`define READ_PORTS 2

`endif

// ==== tracker_tb.sv ====
`timescale 1ns/1ns
`include "tracker_settings.svh"

module tracker_tb;
    import tracker_pkg::*;

    localparam int OPS         = 300;
    localparam int CYCLE_LIMIT = 40 * OPS;
    localparam int TESTS       = 5;

    logic        clk;
    logic        rst;
    logic        fetch_valid;
    fetch_pkt_t  fetch;
    logic        id_available;
    id_t         free_id;
    id_t         decode_id;
    logic [31:0] decode_pc;
    instr_word_u decode_word;
    logic        issue_valid;
    issue_pkt_t  issue;
    id_t         rs_id [`READ_PORTS];
    logic        rs_inuse [`READ_PORTS];
    logic        complete_valid;
    id_t         complete_id;
    logic        retire_valid;
    retire_pkt_t retire;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    logic [31:0] pc_m [`MAX_IDS];
    instr_word_u word_m [`MAX_IDS];
    logic        in_flight_m [`MAX_IDS];
    logic        completed_m [`MAX_IDS];
    id_t         rename_m [32];
    // Rename state before the latest edge, used by the retire decision
    id_t         rename_prev [32];
    id_t         free_q [$];
    id_t         fetched_q [$];
    id_t         order_q [$];
    id_t         pending_q [$];

    string test_name [TESTS] = '{"fetch_decode", "operand_lookup", "in_order_retire",
                                 "retire_fields", "id_exhaustion"};
    int    checks [TESTS]    = '{default: 0};
    int    errors [TESTS]    = '{default: 0};
    int    accepted          = 0;
    int    dropped           = 0;
    int    overwritten       = 0;
    int    cycles            = 0;
    int    total_checks      = 0;
    int    total_errors      = 0;
    id_t   last_fetch_id     = '0;
    logic  fetch_seen        = 1'b0;
    logic  retire_seen       = 1'b0;
    id_t   retire_seen_id    = '0;
    logic  run_done          = 1'b0;

    instr_tracker_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid    (fetch_valid),
        .fetch          (fetch),
        .id_available   (id_available),
        .free_id        (free_id),
        .decode_id      (decode_id),
        .decode_pc      (decode_pc),
        .decode_word    (decode_word),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .rs_id          (rs_id),
        .rs_inuse       (rs_inuse),
        .complete_valid (complete_valid),
        .complete_id    (complete_id),
        .retire_valid   (retire_valid),
        .retire         (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAIL");
        $finish;
    end

    task automatic check_equal(input int t, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks[t]++;
        if (act !== exp) begin
            errors[t]++;
            $display("Fail %s %s: expected %0h, actual %0h", test_name[t], what, exp, act);
        end
    endtask

    task automatic report_problem(input int t, input string msg);
        errors[t]++;
        $display("Error in %s: %s", test_name[t], msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic drive_inputs();
        fetch_pkt_t f;
        issue_pkt_t is;
        logic       i_v;
        logic       c_v;
        id_t        c_id;
        int         k;
        // Small register range so rename hits and x0 show up often
        f.pc               = $urandom & 32'hffff_fffc;
        f.word.raw         = $urandom;
        f.word.fields.rd   = 5'($urandom_range(7, 0));
        f.word.fields.rs1  = 5'($urandom_range(7, 0));
        f.word.fields.rs2  = 5'($urandom_range(7, 0));
        fetch_valid <= (accepted < OPS) && ($urandom_range(99, 0) < 60);
        fetch       <= f;
        // Fetch order is issue order
        is  = '0;
        i_v = (fetched_q.size() > 0) && ($urandom_range(99, 0) < 50);
        if (i_v) begin
            is.id         = fetched_q.pop_front();
            is.uses_rd    = ($urandom_range(3, 0) != 0);
            is.rd_addr    = word_m[is.id].fields.rd;
            is.rs_addr[0] = word_m[is.id].fields.rs1;
            is.rs_addr[1] = word_m[is.id].fields.rs2;
        end
        issue_valid <= i_v;
        issue       <= is;
        // Completions in random order
        c_id = '0;
        c_v  = (pending_q.size() > 0) && ($urandom_range(99, 0) < 40);
        if (c_v) begin
            k    = $urandom_range(pending_q.size() - 1, 0);
            c_id = pending_q[k];
            pending_q.delete(k);
        end
        complete_valid <= c_v;
        complete_id    <= c_id;
        decode_id      <= last_fetch_id;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks at the falling edge

    task automatic check_outputs();
        id_t        src;
        id_t        exp_id;
        logic       exp_inuse;
        logic [4:0] rd;
        check_equal(4, "id_available", 32'(free_q.size() != 0), 32'(id_available));
        if (free_q.size() != 0) begin
            check_equal(4, "free_id", 32'(free_q[0]), 32'(free_id));
        end
        // Table write visible one cycle after the accepting edge
        if (fetch_seen) begin
            check_equal(0, "decode_pc", pc_m[last_fetch_id], decode_pc);
            check_equal(0, "decode_word", word_m[last_fetch_id].raw, decode_word.raw);
        end
        if (issue_valid) begin
            for (int p = 0; p < `READ_PORTS; p++) begin
                src       = rename_m[issue.rs_addr[p]];
                exp_inuse = (issue.rs_addr[p] != 5'd0) && in_flight_m[src]
                            && (word_m[src].fields.rd == issue.rs_addr[p]);
                check_equal(1, $sformatf("rs_id[%0d]", p), 32'(src), 32'(rs_id[p]));
                check_equal(1, $sformatf("rs_inuse[%0d]", p), 32'(exp_inuse),
                            32'(rs_inuse[p]));
            end
        end
        if (retire_valid) begin
            if (order_q.size() == 0) begin
                report_problem(2, "retirement seen with no issued instruction");
            end else begin
                exp_id = order_q.pop_front();
                check_equal(2, "retire id", 32'(exp_id), 32'(retire.id));
                if (!completed_m[exp_id]) begin
                    report_problem(2, $sformatf("ID %0d retired before completion", exp_id));
                end
                rd = word_m[exp_id].fields.rd;
                check_equal(3, "rd_addr", 32'(rd), 32'(retire.rd_addr));
                check_equal(3, "rd_latest", 32'(rename_prev[rd] == exp_id),
                            32'(retire.rd_latest));
                if (rename_prev[rd] != exp_id) begin
                    overwritten++;
                end
                retire_seen    = 1'b1;
                retire_seen_id = exp_id;
            end
        end
    endtask

    // Effect of the coming rising edge on the model
    task automatic advance_model();
        id_t id;
        foreach (rename_prev[r]) begin
            rename_prev[r] = rename_m[r];
        end
        fetch_seen = 1'b0;
        if (fetch_valid) begin
            if (free_q.size() == 0) begin
                dropped++;
            end else begin
                id              = free_q.pop_front();
                pc_m[id]        = fetch.pc;
                word_m[id]      = fetch.word;
                in_flight_m[id] = 1'b1;
                fetched_q.push_back(id);
                last_fetch_id   = id;
                fetch_seen      = 1'b1;
                accepted++;
            end
        end
        if (retire_seen) begin
            free_q.push_back(retire_seen_id);
            in_flight_m[retire_seen_id] = 1'b0;
            completed_m[retire_seen_id] = 1'b0;
            retire_seen = 1'b0;
        end
        if (issue_valid) begin
            if (issue.uses_rd) begin
                rename_m[issue.rd_addr] = issue.id;
            end
            order_q.push_back(issue.id);
            pending_q.push_back(issue.id);
        end
        if (complete_valid) begin
            completed_m[complete_id] = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        void'($urandom(32'h7777_59c5));
        rst            = 1'b1;
        fetch_valid    = 1'b0;
        fetch          = '0;
        decode_id      = '0;
        issue_valid    = 1'b0;
        issue          = '0;
        complete_valid = 1'b0;
        complete_id    = '0;
        for (int i = 0; i < `MAX_IDS; i++) begin
            free_q.push_back(id_t'(i));
            in_flight_m[i] = 1'b0;
            completed_m[i] = 1'b0;
        end
        foreach (rename_m[r]) begin
            rename_m[r] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        while (!run_done) begin
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            check_outputs();
            advance_model();
            run_done = (accepted == OPS) && (fetched_q.size() == 0) && (order_q.size() == 0);
        end
        if (dropped == 0) begin
            report_problem(4, "no fetch was dropped while all IDs were in flight");
        end
        if (overwritten == 0) begin
            report_problem(3, "no retirement had a younger writer of its rd");
        end
        for (int t = 0; t < TESTS; t++) begin
            $display("%s: %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("Total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
